// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= stack_cpu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/stack_cpu_checker.sv ====
`timescale 1ns/1ps
`include "stack_cfg.svh"

module stack_cpu_checker import stack_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   load_en,
    input  logic [`ADDR_WIDTH-1:0] load_addr,
    input  logic [`DATA_WIDTH-1:0] load_data,
    input  logic [`ADDR_WIDTH-1:0] dbg_addr,
    input  logic [`DATA_WIDTH-1:0] dbg_data,
    input  logic                   retire,
    input  logic                   fault,
    input  logic                   halted,
    input  logic [`ADDR_WIDTH-1:0] pc,
    input  logic [`DATA_WIDTH-1:0] sp,
    input  logic                   is_kernel,
    input  mem_req_t               mem_wr,
    output int                     error_count,
    output int                     retire_count,
    output int                     dbg_checks
);

    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] sp;
        logic                   kernel;
    } arch_t;

    typedef struct packed {
        arch_t    next;
        mem_req_t wr;                  // Expected core write
        logic     fault;
        logic     halt;
    } step_t;

    logic [`DATA_WIDTH-1:0] model_mem [1 << `ADDR_WIDTH];
    bit                     known [1 << `ADDR_WIDTH];     // Word written by load or model
    arch_t                  model;
    logic                   running;
    logic                   ran_once;
    logic                   dbg_pending;
    logic [`ADDR_WIDTH-1:0] dbg_q;

    initial begin
        error_count  = 0;
        retire_count = 0;
        dbg_checks   = 0;
    end

    function automatic step_t ref_step(arch_t cur, logic [`DATA_WIDTH-1:0] word);
        step_t                  res;
        logic [`DATA_WIDTH-1:0] top;
        logic [`DATA_WIDTH-1:0] bottom;
        logic [`ADDR_WIDTH-1:0] maddr;
        res         = '0;
        res.next    = cur;
        res.next.pc = cur.pc + 1'b1;
        top         = cur.kernel ? `PRIV_STACK_TOP : `USER_STACK_TOP;
        bottom      = cur.kernel ? `PRIV_STACK_BOTTOM : `USER_STACK_BOTTOM;
        maddr       = word[`ADDR_WIDTH-1:0];
        case (word[31:28])
            PUSHI, PUSHM: begin
                if (cur.sp == `SP_EMPTY) begin
                    res.next.sp = bottom;
                end else if (cur.sp == top) begin
                    res.fault = 1'b1;          // Full stack
                end else begin
                    res.next.sp = cur.sp - 1;
                end
                res.wr.wr_en = !res.fault;
                res.wr.addr  = res.next.sp[`ADDR_WIDTH-1:0];
                res.wr.wdata = (word[31:28] == PUSHI) ? {4'h0, word[27:0]} : model_mem[maddr];
            end
            POPM: begin
                res.fault    = (cur.sp == `SP_EMPTY);
                res.wr.wr_en = !res.fault;
                res.wr.addr  = maddr;
                res.wr.wdata = model_mem[cur.sp[`ADDR_WIDTH-1:0]];
                if (!res.fault) begin
                    res.next.sp = (cur.sp == bottom) ? `SP_EMPTY : cur.sp + 1;
                end
            end
            SETK, SETU: begin
                res.next.sp     = `SP_EMPTY;
                res.next.kernel = (word[31:28] == SETK);
            end
            HALT:    res.halt = 1'b1;
            default: res.halt = 1'b0;         // NOP
        endcase
        return res;
    endfunction

    task automatic expect_equal(string what, logic [`DATA_WIDTH-1:0] got,
                                logic [`DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin : monitor
        step_t res;
        if (rst) begin
            running     = 1'b0;
            ran_once    = 1'b0;
            dbg_pending = 1'b0;
        end else begin
            // Halted only between a HALT and the next start
            expect_equal("halted", 32'(halted), 32'(ran_once && !running));
            if (ran_once && !running) begin
                expect_equal("pc after halt", 32'(pc), 32'(model.pc));
            end
            if (dbg_pending && known[dbg_q]) begin    // Word addressed one cycle ago
                dbg_checks++;
                expect_equal("dbg_data", dbg_data, model_mem[dbg_q]);
            end
            dbg_pending = halted && !load_en;
            dbg_q       = dbg_addr;
            if ((fault || mem_wr.wr_en) && !retire) begin
                error_count++;
                $display("Fault or memory write seen without retire at %0d ns", $time);
            end
            if (retire && !running) begin
                error_count++;
                $display("Instruction retired while the core was stopped at %0d ns", $time);
            end else if (retire) begin
                res = ref_step(model, model_mem[model.pc]);
                expect_equal("pc", 32'(pc), 32'(model.pc));
                expect_equal("sp", sp, model.sp);
                expect_equal("is_kernel", 32'(is_kernel), 32'(model.kernel));
                expect_equal("fault", 32'(fault), 32'(res.fault));
                expect_equal("mem_wr.wr_en", 32'(mem_wr.wr_en), 32'(res.wr.wr_en));
                if (res.wr.wr_en) begin
                    expect_equal("mem_wr.addr", 32'(mem_wr.addr), 32'(res.wr.addr));
                    expect_equal("mem_wr.wdata", mem_wr.wdata, res.wr.wdata);
                    model_mem[res.wr.addr] = res.wr.wdata;
                    known[res.wr.addr]     = 1'b1;
                end
                model   = res.next;
                running = !res.halt;
                retire_count++;
            end
            if (load_en && !running) begin
                model_mem[load_addr] = load_data;
                known[load_addr]     = 1'b1;
            end
            if (start && !running) begin
                model    = '{pc: '0, sp: `SP_EMPTY, kernel: 1'b1};
                running  = 1'b1;
                ran_once = 1'b1;
            end
        end
    end

endmodule

// ==== dv/stack_cpu_tb.sv ====
`timescale 1ns/1ps
`include "stack_cfg.svh"

module stack_cpu_tb import stack_pkg::*; ();

    localparam int     CLK_PERIOD   = 40;
    localparam int     DRIVE_DELAY  = 2;
    localparam int     NUM_PROGS    = 6;
    localparam int     MAX_PROG_LEN = 2100;     // Stack fill program is the longest
    localparam int     DATA_WORDS   = 64;
    localparam int     STACK_WORDS  = `PRIV_STACK_BOTTOM - `PRIV_STACK_TOP + 1;
    localparam longint WATCHDOG_NS  =
        longint'(NUM_PROGS) * (MAX_PROG_LEN * 4 + 200) * CLK_PERIOD;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   load_en;
    logic [`ADDR_WIDTH-1:0] load_addr;
    logic [`DATA_WIDTH-1:0] load_data;
    logic [`ADDR_WIDTH-1:0] dbg_addr;
    logic [`DATA_WIDTH-1:0] dbg_data;
    logic                   retire;
    logic                   fault;
    logic                   halted;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] sp;
    logic                   is_kernel;
    mem_req_t               mem_wr;
    int                     error_count;
    int                     retire_count;
    int                     dbg_checks;
    int                     expected_retires;
    int                     tb_errors;
    logic [`DATA_WIDTH-1:0] prog [$];

    stack_cpu_top i_stack_cpu_top (.*);

    stack_cpu_checker i_stack_cpu_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns with a program still running", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    function automatic logic [`DATA_WIDTH-1:0] encode_instr(opcode_e op, logic [27:0] operand);
        return {op, operand};
    endfunction

    function automatic logic [27:0] pick_data_addr();    // Inside the loaded data window
        return 28'(`DATA_AREA_BASE + $urandom_range(0, DATA_WORDS - 1));
    endfunction

    task automatic build_fill_program();
        prog.delete();
        for (int i = 0; i < STACK_WORDS; i++) begin
            prog.push_back(encode_instr(PUSHI, 28'($urandom)));
        end
        prog.push_back(encode_instr(PUSHI, 28'h0bad));          // Overflow
        prog.push_back(encode_instr(PUSHM, pick_data_addr()));  // Overflow
        prog.push_back(encode_instr(POPM, pick_data_addr()));
        prog.push_back(encode_instr(POPM, pick_data_addr()));
        prog.push_back(encode_instr(SETU, '0));
        prog.push_back(encode_instr(POPM, pick_data_addr()));   // Underflow
        prog.push_back(encode_instr(PUSHM, pick_data_addr()));  // First user slot 8191
        prog.push_back(encode_instr(PUSHI, 28'h1234));
        prog.push_back(encode_instr(POPM, pick_data_addr()));
        prog.push_back(encode_instr(POPM, pick_data_addr()));   // Last item
        prog.push_back(encode_instr(POPM, pick_data_addr()));   // Underflow
        prog.push_back(encode_instr(SETK, '0));
        prog.push_back(encode_instr(PUSHI, 28'h77));
        prog.push_back(encode_instr(NOP, '0));
        prog.push_back(encode_instr(HALT, '0));
    endtask

    task automatic build_random_program(int len);
        int pick;
        prog.delete();
        for (int i = 0; i < len; i++) begin
            pick = $urandom_range(0, 9);
            case (pick)
                0:       prog.push_back(encode_instr(NOP, '0));
                1, 2, 3: prog.push_back(encode_instr(PUSHI, 28'($urandom)));
                4:       prog.push_back(encode_instr(PUSHM, pick_data_addr()));
                5, 6, 7: prog.push_back(encode_instr(POPM, pick_data_addr()));
                8:       prog.push_back(encode_instr(SETK, '0));
                default: prog.push_back(encode_instr(SETU, '0));
            endcase
        end
        prog.push_back(encode_instr(HALT, '0));
    endtask

    task automatic write_word(logic [`ADDR_WIDTH-1:0] addr, logic [`DATA_WIDTH-1:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
    endtask

    task automatic load_image();
        foreach (prog[i]) begin
            write_word(`ADDR_WIDTH'(i), prog[i]);
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            write_word(`ADDR_WIDTH'(`DATA_AREA_BASE + i), $urandom);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        load_en = 1'b0;
    endtask

    task automatic run_to_halt();
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        while (!halted) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic read_data_area();
        for (int i = 0; i < DATA_WORDS; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            dbg_addr = `ADDR_WIDTH'(`DATA_AREA_BASE + i);
        end
        repeat (2) @(posedge clk);        // Last word reaches the checker
    endtask

    initial begin
        rst              = 1'b1;
        start            = 1'b0;
        load_en          = 1'b0;
        load_addr        = '0;
        load_data        = '0;
        dbg_addr         = '0;
        expected_retires = 0;
        tb_errors        = 0;
        void'($urandom(32'h3693));
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            if (p == 0) begin
                build_fill_program();
            end else begin
                build_random_program($urandom_range(20, 60));
            end
            expected_retires += prog.size();
            load_image();
            run_to_halt();
            read_data_area();
        end
        if (retire_count != expected_retires) begin
            tb_errors++;
            $display("Retired %0d instructions, but the programs hold %0d",
                     retire_count, expected_retires);
        end
        if (dbg_checks < NUM_PROGS * DATA_WORDS) begin
            tb_errors++;
            $display("Only %0d debug reads were compared with the model", dbg_checks);
        end
        $display("Run finished with %0d checker errors and %0d testbench errors",
                 error_count, tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+source
source/stack_pkg.sv
source/mem_addr_handler.sv
source/cpu_control_fsm.sv
source/pc_sp_regs.sv
source/unified_mem.sv
source/stack_cpu_top.sv
dv/stack_cpu_checker.sv
dv/stack_cpu_tb.sv

// ==== source/cpu_control_fsm.sv ====
`timescale 1ns/1ps
`include "stack_cfg.svh"

module cpu_control_fsm import stack_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [`DATA_WIDTH-1:0] mem_rdata,
    input  logic [`ADDR_WIDTH-1:0] pc,
    input  logic [`ADDR_WIDTH-1:0] stack_addr,
    input  logic [`ADDR_WIDTH-1:0] data_addr,
    input  logic                   stack_fault,
    input  sp_ctrl_e               sp_ctrl_in,
    output cpu_state_e             state,
    output instr_t                 instr,
    output logic [`DATA_WIDTH-1:0] operand_word,
    output logic                   pc_load,
    output logic                   sp_load,
    output logic                   mode_load,
    output logic                   mode_kernel,
    output mem_req_t               core_req,
    output logic                   retire,
    output logic                   fault,
    output logic                   halted
);

    cpu_state_e next_state;
    instr_t     fetched;
    logic       writes_mem;

    assign fetched = instr_t'(mem_rdata);  // Valid in DECODE

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            instr <= fetched;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE, HALTED: if (start) next_state = FETCH;
            FETCH:        next_state = DECODE;
            DECODE: begin
                case (fetched.opcode)
                    HALT:        next_state = HALTED;
                    PUSHM, POPM: next_state = READ;
                    default:     next_state = WRITE;
                endcase
            end
            READ:         next_state = WRITE;
            default:      next_state = FETCH;    // WRITE retires
        endcase
    end

    // Immediate for PUSHI, otherwise the word read in READ
    assign operand_word = (instr.opcode == PUSHI) ? `DATA_WIDTH'(instr.operand) : mem_rdata;
    assign writes_mem   = (instr.opcode inside {PUSHI, PUSHM, POPM}) && !stack_fault;

    always_comb begin
        core_req = '0;
        case (state)
            FETCH: core_req.addr = pc;
            READ:  core_req.addr = (instr.opcode == PUSHM) ? data_addr : stack_addr;
            WRITE: begin
                core_req.wr_en = writes_mem;
                core_req.addr  = (instr.opcode == POPM) ? data_addr : stack_addr;
                core_req.wdata = operand_word;
            end
            default: core_req = '0;
        endcase
    end

    assign retire      = (state == WRITE) || ((state == DECODE) && (fetched.opcode == HALT));
    assign fault       = (state == WRITE) && stack_fault;
    assign pc_load     = retire;
    assign sp_load     = (state == WRITE) && (sp_ctrl_in != SP_HOLD);
    assign mode_load   = (state == WRITE) && (instr.opcode inside {SETK, SETU});
    assign mode_kernel = (instr.opcode == SETK);
    assign halted      = (state == HALTED);

    a_retire_state: assert property (@(posedge clk) disable iff (rst)
        retire |-> !(state inside {IDLE, HALTED}) ##1 (state inside {FETCH, HALTED}))
        else $error("retire outside an instruction's last cycle");

    // A faulting stack op must leave memory and SP alone
    a_fault_quiet: assert property (@(posedge clk) disable iff (rst)
        fault |-> retire && !core_req.wr_en && !sp_load)
        else $error("fault without clean retire");

endmodule

// ==== source/mem_addr_handler.sv ====
`timescale 1ns/1ps
`include "stack_cfg.svh"

module mem_addr_handler import stack_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`ADDR_WIDTH-1:0] pc,
    input  logic [`DATA_WIDTH-1:0] sp,
    input  logic                   is_kernel,
    input  opcode_e                opcode,
    input  logic [`ADDR_WIDTH-1:0] operand_addr,
    output logic [`ADDR_WIDTH-1:0] next_pc,
    output logic [`DATA_WIDTH-1:0] next_sp,
    output sp_ctrl_e               sp_ctrl,
    output logic [`ADDR_WIDTH-1:0] stack_addr,
    output logic [`ADDR_WIDTH-1:0] data_addr,
    output logic                   stack_fault
);

    logic [`DATA_WIDTH-1:0] min_stack;
    logic [`DATA_WIDTH-1:0] max_stack;
    logic                   stack_empty;
    logic                   has_room;
    logic                   has_many;
    logic                   is_push;

    assign next_pc   = pc + 1'b1;
    assign data_addr = operand_addr;   // No protection on the data area

    // Stack grows downward, top is the lowest address
    assign min_stack = is_kernel ? `PRIV_STACK_TOP : `USER_STACK_TOP;
    assign max_stack = is_kernel ? `PRIV_STACK_BOTTOM : `USER_STACK_BOTTOM;

    assign stack_empty = (sp == `SP_EMPTY);
    assign has_room    = !stack_empty && (sp > min_stack);    // Not full
    assign has_many    = !stack_empty && (sp < max_stack);    // More than one item
    assign is_push     = (opcode == PUSHI) || (opcode == PUSHM);

    always_comb begin
        sp_ctrl     = SP_HOLD;
        stack_fault = 1'b0;
        case (opcode)
            PUSHI, PUSHM: begin
                if (stack_empty) begin
                    sp_ctrl = SP_LOAD_BOTTOM;
                end else if (has_room) begin
                    sp_ctrl = SP_DEC;
                end else begin
                    stack_fault = 1'b1;       // Overflow, SP stays put
                end
            end
            POPM: begin
                if (stack_empty) begin
                    stack_fault = 1'b1;       // Underflow
                end else if (has_many) begin
                    sp_ctrl = SP_INC;
                end else begin
                    sp_ctrl = SP_SET_EMPTY;
                end
            end
            SETK, SETU: sp_ctrl = SP_SET_EMPTY;
            default:    sp_ctrl = SP_HOLD;
        endcase
    end

    always_comb begin
        case (sp_ctrl)
            SP_INC:         next_sp = sp + 1'b1;
            SP_DEC:         next_sp = sp - 1'b1;
            SP_LOAD_BOTTOM: next_sp = max_stack;
            SP_SET_EMPTY:   next_sp = `SP_EMPTY;
            default:        next_sp = sp;
        endcase
    end

    // Push writes the new slot, pop reads the current one
    assign stack_addr = is_push ? next_sp[`ADDR_WIDTH-1:0] : sp[`ADDR_WIDTH-1:0];

    // Holds only while SP and mode registers stay consistent across updates
    a_sp_in_bounds: assert property (@(posedge clk) disable iff (rst)
        (next_sp != `SP_EMPTY) |-> (next_sp >= min_stack) && (next_sp <= max_stack))
        else $error("next_sp %0h outside active stack", next_sp);

endmodule

// ==== source/pc_sp_regs.sv ====
`timescale 1ns/1ps
`include "stack_cfg.svh"

module pc_sp_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   pc_load,
    input  logic [`ADDR_WIDTH-1:0] next_pc,
    input  logic                   sp_load,
    input  logic [`DATA_WIDTH-1:0] next_sp,
    input  logic                   mode_load,
    input  logic                   mode_kernel,
    output logic [`ADDR_WIDTH-1:0] pc,
    output logic [`DATA_WIDTH-1:0] sp,
    output logic                   is_kernel
);

    always_ff @(posedge clk) begin
        if (rst || start) begin
            pc        <= '0;
            sp        <= `SP_EMPTY;
            is_kernel <= 1'b1;            // Programs start privileged
        end else begin
            if (pc_load) begin
                pc <= next_pc;
            end
            if (sp_load) begin
                sp <= next_sp;
            end
            if (mode_load) begin
                is_kernel <= mode_kernel;
            end
        end
    end

    a_pc_in_code: assert property (@(posedge clk) disable iff (rst)
        pc_load |=> (pc < `CODE_AREA_SIZE))
        else $error("pc %0d left the code area", pc);

    // Start is only honored while no instruction is in flight
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !pc_load && !sp_load && !mode_load)
        else $error("start collided with a register update");

endmodule

// ==== source/stack_cfg.svh ====
`ifndef STACK_CFG_SVH
`define STACK_CFG_SVH

// Word address and data widths
`define ADDR_WIDTH        14
`define DATA_WIDTH        32
`define OPCODE_WIDTH      4

// Memory map, word addresses
`define CODE_AREA_SIZE    4096         // Code at 0 .. 4095
`define PRIV_STACK_TOP    4096         // Lowest kernel stack word
`define PRIV_STACK_BOTTOM 6143         // First kernel push lands here
`define USER_STACK_TOP    6144         // Lowest user stack word
`define USER_STACK_BOTTOM 8191         // First user push lands here
`define DATA_AREA_BASE    8192         // Data up to the top of memory

// SP value of an empty stack
`define SP_EMPTY          32'hffff_ffff

`endif

// ==== source/stack_cpu_top.sv ====
`timescale 1ns/1ps
`include "stack_cfg.svh"

module stack_cpu_top import stack_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   load_en,
    input  logic [`ADDR_WIDTH-1:0] load_addr,
    input  logic [`DATA_WIDTH-1:0] load_data,
    input  logic [`ADDR_WIDTH-1:0] dbg_addr,
    output logic [`DATA_WIDTH-1:0] dbg_data,
    output logic                   retire,
    output logic                   fault,
    output logic                   halted,
    output logic [`ADDR_WIDTH-1:0] pc,
    output logic [`DATA_WIDTH-1:0] sp,
    output logic                   is_kernel,
    output mem_req_t               mem_wr
);

    cpu_state_e             state;
    instr_t                 instr;
    logic [`DATA_WIDTH-1:0] operand_word;
    logic                   pc_load;
    logic                   sp_load;
    logic                   mode_load;
    logic                   mode_kernel;
    mem_req_t               core_req;
    mem_req_t               ext_req;
    mem_req_t               mem_req;
    logic [`DATA_WIDTH-1:0] mem_rdata;
    logic [`ADDR_WIDTH-1:0] next_pc;
    logic [`DATA_WIDTH-1:0] next_sp;
    sp_ctrl_e               sp_ctrl;
    logic [`ADDR_WIDTH-1:0] stack_addr;
    logic [`ADDR_WIDTH-1:0] data_addr;
    logic                   stack_fault;
    logic                   core_busy;
    logic                   start_go;

    assign core_busy = !(state inside {IDLE, HALTED});
    assign start_go  = start && !core_busy;

    // External port: load writes win over debug reads
    assign ext_req.wr_en = load_en;
    assign ext_req.addr  = load_en ? load_addr : dbg_addr;
    assign ext_req.wdata = load_data;

    assign mem_req  = core_busy ? core_req : ext_req;
    assign dbg_data = mem_rdata;

    // Mirror of core writes only
    assign mem_wr.wr_en = core_busy && core_req.wr_en;
    assign mem_wr.addr  = core_req.addr;
    assign mem_wr.wdata = operand_word;

    mem_addr_handler i_mem_addr_handler (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .sp          (sp),
        .is_kernel   (is_kernel),
        .opcode      (instr.opcode),
        .operand_addr(instr.operand[`ADDR_WIDTH-1:0]),
        .next_pc     (next_pc),
        .next_sp     (next_sp),
        .sp_ctrl     (sp_ctrl),
        .stack_addr  (stack_addr),
        .data_addr   (data_addr),
        .stack_fault (stack_fault)
    );

    pc_sp_regs i_pc_sp_regs (
        .clk        (clk),
        .rst        (rst),
        .start      (start_go),
        .pc_load    (pc_load),
        .next_pc    (next_pc),
        .sp_load    (sp_load),
        .next_sp    (next_sp),
        .mode_load  (mode_load),
        .mode_kernel(mode_kernel),
        .pc         (pc),
        .sp         (sp),
        .is_kernel  (is_kernel)
    );

    cpu_control_fsm i_cpu_control_fsm (
        .clk         (clk),
        .rst         (rst),
        .start       (start_go),
        .mem_rdata   (mem_rdata),
        .pc          (pc),
        .stack_addr  (stack_addr),
        .data_addr   (data_addr),
        .stack_fault (stack_fault),
        .sp_ctrl_in  (sp_ctrl),
        .state       (state),
        .instr       (instr),
        .operand_word(operand_word),
        .pc_load     (pc_load),
        .sp_load     (sp_load),
        .mode_load   (mode_load),
        .mode_kernel (mode_kernel),
        .core_req    (core_req),
        .retire      (retire),
        .fault       (fault),
        .halted      (halted)
    );

    unified_mem i_unified_mem (
        .clk  (clk),
        .req  (mem_req),
        .rdata(mem_rdata)
    );

    // Loads during a run are dropped by the port mux
    a_no_load_busy: assert property (@(posedge clk) disable iff (rst)
        core_busy |-> !load_en)
        else $error("load_en while core is running, write ignored");

endmodule

// ==== source/stack_pkg.sv ====
`include "stack_cfg.svh"

package stack_pkg;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        NOP   = 4'h0,
        PUSHI = 4'h1,                  // Push zero-extended immediate
        PUSHM = 4'h2,                  // Push mem[operand]
        POPM  = 4'h3,                  // Pop into mem[operand]
        SETK  = 4'h4,                  // Kernel mode, empty stack
        SETU  = 4'h5,                  // User mode, empty stack
        HALT  = 4'h6
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        READ,
        WRITE,
        HALTED
    } cpu_state_e;

    typedef enum logic [2:0] {
        SP_HOLD,
        SP_INC,                        // Pop with items left
        SP_DEC,                        // Push onto non-empty stack
        SP_LOAD_BOTTOM,                // First push
        SP_SET_EMPTY                   // Last pop or mode switch
    } sp_ctrl_e;

    typedef struct packed {
        opcode_e                                   opcode;
        logic [`DATA_WIDTH-`OPCODE_WIDTH-1:0]      operand;
    } instr_t;

    typedef struct packed {
        logic                   wr_en;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
    } mem_req_t;

endpackage

// ==== source/unified_mem.sv ====
`timescale 1ns/1ps
`include "stack_cfg.svh"

module unified_mem import stack_pkg::*; (
    input  logic                   clk,
    input  mem_req_t               req,
    output logic [`DATA_WIDTH-1:0] rdata
);

    localparam int MEM_WORDS = 1 << `ADDR_WIDTH;    // 16384 words

    logic [`DATA_WIDTH-1:0] mem [MEM_WORDS];

    // Read-first single port
    always_ff @(posedge clk) begin
        if (req.wr_en) begin
            mem[req.addr] <= req.wdata;
        end
        rdata <= mem[req.addr];
    end

endmodule
